//--- mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// datapath widths
`define MEM_ADDR_W      64
`define MEM_DATA_W      64
`define MEM_LINE_W      128

// direct-mapped dcache, 16 lines of 16 bytes
`define DCACHE_SETS     16
`define DCACHE_INDEX_W  4
`define DCACHE_TAG_W    56

// memory op codes
// bits 1:0 size (00 word, 01 byte, 10 half, 11 dword), bit 2 zero-extend
`define MEM_OP_LW       3'd0
`define MEM_OP_LB       3'd1
`define MEM_OP_LH       3'd2
`define MEM_OP_LD       3'd3
`define MEM_OP_LWU      3'd4
`define MEM_OP_LBU      3'd5
`define MEM_OP_LHU      3'd6

`endif

//--- mem_pkg.sv
`include "mem_consts.svh"

package mem_pkg;

    typedef logic [`MEM_DATA_W-1:0] dword_t;
    typedef logic [`MEM_LINE_W-1:0] line_t;
    typedef logic [2:0]             mem_op_t;

    // request as issued by the core
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        mem_op_t                op;
        logic                   we;    // 1 for a store
    } mem_req_t;

    // access after byte-lane alignment
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0]   addr;
        logic                     we;
        dword_t                   data;
        logic [`MEM_DATA_W/8-1:0] mask;
    } cache_req_t;

    // line transfer toward external memory
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;  // line aligned
        logic                   we;
        line_t                  line;
    } bus_req_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL,
        ST_DONE
    } ctrl_state_t;

endpackage

//--- store_align.sv
module store_align (
    input  mem_pkg::mem_req_t   req_i,
    input  mem_pkg::dword_t     wdata_i,
    output mem_pkg::cache_req_t creq_o
);
    import mem_pkg::*;

    logic [2:0] offset;
    dword_t     data_low;   // store data before the lane shift
    logic [7:0] mask_low;

    assign offset = req_i.addr[2:0];

    always_comb begin
        case (req_i.op[1:0])
            2'b01: begin
                data_low = dword_t'(wdata_i[7:0]);
                mask_low = 8'h01;
            end
            2'b10: begin
                data_low = dword_t'(wdata_i[15:0]);
                mask_low = 8'h03;
            end
            2'b00: begin
                data_low = dword_t'(wdata_i[31:0]);
                mask_low = 8'h0f;
            end
            default: begin
                data_low = wdata_i;
                mask_low = 8'hff;
            end
        endcase
    end

    // aligned access assumed, so nothing spills past the dword
    always_comb begin
        creq_o.addr = req_i.addr;
        creq_o.we   = req_i.we;
        creq_o.data = data_low << {offset, 3'b000};
        creq_o.mask = mask_low << offset;
    end

endmodule

//--- load_extract.sv
`include "mem_consts.svh"

module load_extract (
    input  mem_pkg::mem_op_t op_i,
    input  logic [2:0]       offset_i,
    input  mem_pkg::dword_t  dword_i,
    output mem_pkg::dword_t  rdata_o
);
    import mem_pkg::*;

    dword_t      shifted;
    logic [31:0] w;
    logic [15:0] h;
    logic [7:0]  b;

    // addressed bytes moved down to lane 0
    assign shifted = dword_i >> {offset_i, 3'b000};
    assign w = shifted[31:0];
    assign h = shifted[15:0];
    assign b = shifted[7:0];

    always_comb begin
        case (op_i)
            `MEM_OP_LW: begin
                rdata_o = {{32{w[31]}}, w};
            end
            `MEM_OP_LB: begin
                rdata_o = {{56{b[7]}}, b};
            end
            `MEM_OP_LH: begin
                rdata_o = {{48{h[15]}}, h};
            end
            `MEM_OP_LD: begin
                rdata_o = shifted;
            end
            `MEM_OP_LWU: begin
                rdata_o = {32'b0, w};
            end
            `MEM_OP_LBU: begin
                rdata_o = {56'b0, b};
            end
            `MEM_OP_LHU: begin
                rdata_o = {48'b0, h};
            end
            default: begin
                rdata_o = '0;   // code 7
            end
        endcase
    end

endmodule

//--- dcache_ctrl.sv
`include "mem_consts.svh"

module dcache_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start_i,
    input  mem_pkg::cache_req_t        creq_i,
    output logic                       busy_o,
    output logic                       done_o,
    output mem_pkg::dword_t            dword_o,
    output logic [`DCACHE_INDEX_W-1:0] index_o,
    input  logic [`DCACHE_TAG_W-1:0]   tag_i,
    input  logic                       valid_i,
    input  logic                       dirty_i,
    input  mem_pkg::line_t             line_i,
    output logic                       wr_en_o,
    output logic [7:0]                 wr_mask_o,
    output mem_pkg::dword_t            wr_data_o,
    output logic                       fill_en_o,
    output mem_pkg::line_t             fill_line_o,
    output mem_pkg::bus_req_t          bus_req_o,
    output logic                       bus_valid_o,
    input  logic                       bus_ready_i,
    input  mem_pkg::line_t             bus_rdata_i
);
    import mem_pkg::*;

    localparam int OFS_W = `MEM_ADDR_W - `DCACHE_TAG_W - `DCACHE_INDEX_W;

    ctrl_state_t               state;
    logic [`DCACHE_TAG_W-1:0]  req_tag;
    logic                      hit;
    logic                      xfer_done;
    dword_t                    dword_q;
    bus_req_t                  bus_req_q;
    bus_req_t                  wb_req;
    bus_req_t                  fill_req;
    logic                      bus_valid_q;

    assign req_tag = creq_i.addr[`MEM_ADDR_W-1 -: `DCACHE_TAG_W];
    assign index_o = creq_i.addr[OFS_W +: `DCACHE_INDEX_W];
    assign hit     = valid_i && (tag_i == req_tag);
    assign xfer_done = bus_valid_q && bus_ready_i;

    // victim line out, requested line in
    always_comb begin
        wb_req.addr   = {tag_i, index_o, {OFS_W{1'b0}}};
        wb_req.we     = 1'b1;
        wb_req.line   = line_i;
        fill_req.addr = {req_tag, index_o, {OFS_W{1'b0}}};
        fill_req.we   = 1'b0;
        fill_req.line = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            bus_valid_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_i) state <= ST_LOOKUP;
                end
                ST_LOOKUP: begin
                    if (hit) state <= ST_DONE;
                    else if (valid_i && dirty_i) state <= ST_WRITEBACK;
                    else state <= ST_REFILL;
                end
                ST_WRITEBACK, ST_REFILL: begin
                    if (!bus_valid_q) begin
                        bus_valid_q <= 1'b1;   // request already latched
                    end else if (bus_ready_i) begin
                        bus_valid_q <= 1'b0;
                        state <= (state == ST_WRITEBACK) ? ST_REFILL : ST_LOOKUP;
                    end
                end
                ST_DONE: begin
                    state <= start_i ? ST_LOOKUP : ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_LOOKUP && hit) begin
            dword_q <= creq_i.addr[3] ? line_i[127:64] : line_i[63:0];
        end
        if (state == ST_LOOKUP && !hit) begin
            bus_req_q <= (valid_i && dirty_i) ? wb_req : fill_req;
        end
        if (state == ST_WRITEBACK && xfer_done) begin
            bus_req_q <= fill_req;
        end
    end

    assign wr_en_o     = (state == ST_LOOKUP) && hit && creq_i.we;
    assign wr_mask_o   = creq_i.mask;
    assign wr_data_o   = creq_i.data;
    assign fill_en_o   = (state == ST_REFILL) && xfer_done;
    assign fill_line_o = bus_rdata_i;

    assign busy_o      = (state == ST_LOOKUP) || (state == ST_WRITEBACK) ||
                         (state == ST_REFILL);
    assign done_o      = (state == ST_DONE);
    assign dword_o     = dword_q;
    assign bus_req_o   = bus_req_q;
    assign bus_valid_o = bus_valid_q;

endmodule

//--- dcache_store.sv
`include "mem_consts.svh"

module dcache_store (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`DCACHE_INDEX_W-1:0] index_i,
    input  logic                       wr_en_i,
    input  logic                       wr_sel_i,    // upper or lower dword
    input  logic [7:0]                 wr_mask_i,
    input  mem_pkg::dword_t            wr_data_i,
    input  logic                       fill_en_i,
    input  logic [`DCACHE_TAG_W-1:0]   fill_tag_i,
    input  mem_pkg::line_t             fill_line_i,
    output logic [`DCACHE_TAG_W-1:0]   tag_o,
    output logic                       valid_o,
    output logic                       dirty_o,
    output mem_pkg::line_t             line_o
);
    import mem_pkg::*;

    line_t                    line_q [`DCACHE_SETS];
    logic [`DCACHE_TAG_W-1:0] tag_q  [`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0]  valid_q;
    logic [`DCACHE_SETS-1:0]  dirty_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_en_i) begin
            valid_q[index_i] <= 1'b1;
            dirty_q[index_i] <= 1'b0;   // refilled line is clean
        end else if (wr_en_i) begin
            dirty_q[index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        int b;
        if (fill_en_i) begin
            line_q[index_i] <= fill_line_i;
            tag_q[index_i]  <= fill_tag_i;
        end else if (wr_en_i) begin
            for (b = 0; b < 8; b++) begin
                if (wr_mask_i[b]) begin
                    line_q[index_i][{wr_sel_i, 6'(b * 8)} +: 8] <= wr_data_i[b*8 +: 8];
                end
            end
        end
    end

    // combinational read of the indexed set
    assign tag_o   = tag_q[index_i];
    assign valid_o = valid_q[index_i];
    assign dirty_o = dirty_q[index_i];
    assign line_o  = line_q[index_i];

endmodule

//--- mem_access_unit.sv
`include "mem_consts.svh"

module mem_access_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                vis_mem_i,
    input  mem_pkg::mem_req_t   req_i,
    input  mem_pkg::dword_t     wdata_i,
    output logic                busy_o,
    output logic                done_o,
    output mem_pkg::dword_t     rdata_o,
    output mem_pkg::bus_req_t   bus_req_o,
    output logic                bus_valid_o,
    input  logic                bus_ready_i,
    input  mem_pkg::line_t      bus_rdata_i
);
    import mem_pkg::*;

    cache_req_t                 creq;
    dword_t                     raw_dword;
    logic [`DCACHE_INDEX_W-1:0] index;
    logic [`DCACHE_TAG_W-1:0]   tag;
    logic                       valid;
    logic                       dirty;
    line_t                      line;
    logic                       wr_en;
    logic [7:0]                 wr_mask;
    dword_t                     wr_data;
    logic                       fill_en;
    line_t                      fill_line;

    store_align store_align_i (
        .req_i   (req_i),
        .wdata_i (wdata_i),
        .creq_o  (creq)
    );

    dcache_ctrl dcache_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .start_i     (vis_mem_i),
        .creq_i      (creq),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .dword_o     (raw_dword),
        .index_o     (index),
        .tag_i       (tag),
        .valid_i     (valid),
        .dirty_i     (dirty),
        .line_i      (line),
        .wr_en_o     (wr_en),
        .wr_mask_o   (wr_mask),
        .wr_data_o   (wr_data),
        .fill_en_o   (fill_en),
        .fill_line_o (fill_line),
        .bus_req_o   (bus_req_o),
        .bus_valid_o (bus_valid_o),
        .bus_ready_i (bus_ready_i),
        .bus_rdata_i (bus_rdata_i)
    );

    dcache_store dcache_store_i (
        .clk         (clk),
        .rst         (rst),
        .index_i     (index),
        .wr_en_i     (wr_en),
        .wr_sel_i    (creq.addr[3]),
        .wr_mask_i   (wr_mask),
        .wr_data_i   (wr_data),
        .fill_en_i   (fill_en),
        .fill_tag_i  (creq.addr[`MEM_ADDR_W-1 -: `DCACHE_TAG_W]),
        .fill_line_i (fill_line),
        .tag_o       (tag),
        .valid_o     (valid),
        .dirty_o     (dirty),
        .line_o      (line)
    );

    // op and address are held by the core until done_o
    load_extract load_extract_i (
        .op_i     (req_i.op),
        .offset_i (req_i.addr[2:0]),
        .dword_i  (raw_dword),
        .rdata_o  (rdata_o)
    );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;   // 4 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (4) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

//--- tb_mem_model.sv
module tb_mem_model (
    input  logic              clk_i,
    input  logic              rst_i,
    input  mem_pkg::bus_req_t bus_req_i,
    input  logic              bus_valid_i,
    output logic              bus_ready_o,
    output mem_pkg::line_t    bus_rdata_o,
    output logic              xfer_seen_o,
    output mem_pkg::bus_req_t xfer_req_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import mem_pkg::*;

    localparam int MEM_BYTES = 4096;

    logic [7:0] mem [MEM_BYTES];
    int         seed = 40;

    // same fixed pattern as the reference memory in the top
    function automatic logic [7:0] pattern_byte(input int a);
        logic [11:0] x;
        x = 12'(a);
        return x[7:0] ^ {x[3:0], x[11:8]} ^ 8'hc3;
    endfunction

    initial begin
        int          k;
        int          j;
        int          r;
        int          delay;
        logic [11:0] base;
        for (k = 0; k < MEM_BYTES; k++) begin
            mem[12'(k)] = pattern_byte(k);
        end
        bus_ready_o = 1'b0;
        bus_rdata_o = '0;
        xfer_seen_o = 1'b0;
        xfer_req_o  = '0;
        forever begin
            @(posedge clk_i);
            #1;
            if (!rst_i && bus_valid_i) begin
                r = $random(seed);
                delay = 1 + int'(r[30:0]) % 6;   // 1 to 6 cycles
                repeat (delay) @(posedge clk_i);
                #1;
                base = bus_req_i.addr[11:0];
                xfer_req_o = bus_req_i;
                if (bus_req_i.we) begin
                    for (j = 0; j < 16; j++) begin
                        mem[base + 12'(j)] = bus_req_i.line[8*j +: 8];
                    end
                end else begin
                    for (j = 0; j < 16; j++) begin
                        bus_rdata_o[8*j +: 8] = mem[base + 12'(j)];
                    end
                end
                bus_ready_o = 1'b1;
                xfer_seen_o = 1'b1;
                @(posedge clk_i);   // transfer completes here
                #1;
                bus_ready_o = 1'b0;
                xfer_seen_o = 1'b0;
            end
        end
    end

endmodule

//--- tb_mem_access.sv
module tb_mem_access;
    timeunit 1ns;
    timeprecision 1ps;
    import mem_pkg::*;

    localparam int MEM_BYTES = 4096;
    localparam int N_ACCESS  = 2000;
    localparam int TIMEOUT   = 200;

    logic        clk;
    logic        rst;
    logic        vis_mem;
    mem_req_t    req;
    dword_t      wdata;
    logic        busy;
    logic        done;
    dword_t      rdata;
    bus_req_t    bus_req;
    logic        bus_valid;
    logic        bus_ready;
    line_t       bus_rdata;
    logic        xfer_seen;
    bus_req_t    xfer_req;

    logic [7:0]  ref_mem [MEM_BYTES];
    int          seed = 40;

    tb_clock_gen clock_gen_i (
        .clk_o (clk),
        .rst_o (rst)
    );

    mem_access_unit mem_access_unit_i (
        .clk         (clk),
        .rst         (rst),
        .vis_mem_i   (vis_mem),
        .req_i       (req),
        .wdata_i     (wdata),
        .busy_o      (busy),
        .done_o      (done),
        .rdata_o     (rdata),
        .bus_req_o   (bus_req),
        .bus_valid_o (bus_valid),
        .bus_ready_i (bus_ready),
        .bus_rdata_i (bus_rdata)
    );

    tb_mem_model mem_model_i (
        .clk_i       (clk),
        .rst_i       (rst),
        .bus_req_i   (bus_req),
        .bus_valid_i (bus_valid),
        .bus_ready_o (bus_ready),
        .bus_rdata_o (bus_rdata),
        .xfer_seen_o (xfer_seen),
        .xfer_req_o  (xfer_req)
    );

    function automatic logic [7:0] pattern_byte(input int a);
        logic [11:0] x;
        x = 12'(a);
        return x[7:0] ^ {x[3:0], x[11:8]} ^ 8'hc3;
    endfunction

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return int'(r[30:0]) % n;
    endfunction

    // op bits 1:0 give the size
    function automatic int size_bytes(input mem_op_t op);
        case (op[1:0])
            2'b00: return 4;
            2'b01: return 1;
            2'b10: return 2;
            default: return 8;
        endcase
    endfunction

    function automatic dword_t expect_load(input mem_op_t op, input logic [11:0] a);
        dword_t v;
        int     n;
        v = '0;
        n = size_bytes(op);
        if (op == 3'd7) begin
            return '0;   // invalid code reads as zero
        end
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = ref_mem[a + 12'(i)];
        end
        if (!op[2] && n < 8) begin
            for (int i = 8 * n; i < 64; i++) begin
                v[i] = v[8*n-1];
            end
        end
        return v;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_dword(input string name, input dword_t got, input dword_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // rst is sampled on the clock edge, where it is stable
    task automatic wait_for_reset();
        int n;
        n = 0;
        @(posedge clk);
        while (rst) begin
            if (n >= TIMEOUT) begin
                abort_run("timeout waiting for reset to be released");
            end
            @(posedge clk);
            n++;
        end
        #1;
    endtask

    task automatic apply_store(input mem_op_t op, input logic [11:0] a, input dword_t wd);
        for (int i = 0; i < size_bytes(op); i++) begin
            ref_mem[a + 12'(i)] = wd[8*i +: 8];
        end
    endtask

    // one access from start strobe to done pulse
    task automatic do_access(input mem_req_t r, input dword_t wd, input logic expect_hit);
        int cycles;
        req     = r;
        wdata   = wd;
        vis_mem = 1'b1;
        @(posedge clk);
        #1;
        vis_mem = 1'b0;
        cycles  = 1;
        while (!done) begin
            if (!busy) begin
                abort_run("busy_o low while an access is in flight");
            end
            if (expect_hit && bus_valid) begin
                abort_run("bus_valid_o raised on an access to a resident line");
            end
            if (cycles >= TIMEOUT) begin
                abort_run("timeout waiting for done_o");
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        if (busy) begin
            abort_run("busy_o still high in the done_o cycle");
        end
        if (expect_hit && cycles != 2) begin
            abort_run($sformatf("access to a resident line took %0d cycles, not 2", cycles));
        end
        if (r.we) begin
            apply_store(r.op, r.addr[11:0], wd);
        end else begin
            check_dword("rdata_o", rdata, expect_load(r.op, r.addr[11:0]));
        end
    endtask

    // every line going out must match what the core has stored so far
    always @(posedge clk) begin : bus_check
        line_t       exp_line;
        logic [11:0] base;
        if (xfer_seen) begin
            if (xfer_req.addr[3:0] != 4'd0 || xfer_req.addr >= 64'(MEM_BYTES)) begin
                abort_run("bus request address is not line aligned or is out of range");
            end
            if (xfer_req.we) begin
                base = xfer_req.addr[11:0];
                for (int j = 0; j < 16; j++) begin
                    exp_line[8*j +: 8] = ref_mem[base + 12'(j)];
                end
                check_line("bus_req_o.line", xfer_req.line, exp_line);
            end
        end
    end

    initial begin
        int          i;
        int          k;
        int          gap;
        logic        same;
        mem_req_t    r;
        dword_t      wd;
        logic [11:0] a;
        logic [11:0] last_addr;
        vis_mem   = 1'b0;
        req       = '0;
        wdata     = '0;
        last_addr = '0;
        for (k = 0; k < MEM_BYTES; k++) begin
            ref_mem[12'(k)] = pattern_byte(k);
        end
        wait_for_reset();
        if (busy || done || bus_valid) begin
            abort_run("busy_o, done_o or bus_valid_o high after reset");
        end
        for (i = 0; i < N_ACCESS; i++) begin
            same = (i > 0) && (rand_below(4) == 0);   // revisit the last line
            r.op = mem_op_t'(rand_below(8));
            r.we = (rand_below(3) == 0);
            if (r.we) begin
                r.op = {1'b0, r.op[1:0]};
            end
            if (same) begin
                a = {last_addr[11:4], 4'(rand_below(16))};
            end else begin
                a = 12'(rand_below(MEM_BYTES));
            end
            a = a & ~(12'(size_bytes(r.op)) - 12'd1);   // natural alignment
            r.addr = 64'(a);
            wd = {$random(seed), $random(seed)};
            do_access(r, wd, same);
            last_addr = a;
            gap = rand_below(3);
            repeat (gap) begin
                @(posedge clk);
                #1;
                if (done || busy) begin
                    abort_run("done_o or busy_o high while the unit is idle");
                end
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
mem_pkg.sv
store_align.sv
load_extract.sv
dcache_ctrl.sv
dcache_store.sv
mem_access_unit.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_mem_access.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run; exit status is the simulator's
cd "$(dirname "$0")" \
    && verilator --binary --timing -j 0 -f sim.f --top-module tb_mem_access -o tb_sim \
    && ./obj_dir/tb_sim \
    || { echo "simulation failed"; exit 1; }
